// ==== src/gprfile_settings.svh ====
// Sizing for the three-lane GPR file
// ID_WIDTH has to leave the top id bit free for the special register space
// Ids below GPR_COUNT address GPRs, so GPR_COUNT must not exceed half the id space
// IMM_WIDTH counts the sign bit of a decoded immediate
`ifndef GPRFILE_SETTINGS_SVH
`define GPRFILE_SETTINGS_SVH

// GPR array depth
`define GPR_COUNT 32

// Register width
`define VALUE_WIDTH 64

// Immediate incl. sign bit
`define IMM_WIDTH 33

// Register id width
`define ID_WIDTH 6

`endif

// ==== src/gprFilePkg.sv ====
// Types and register ids for the GPR file
// Ids with the top bit set are specials, IMM and ZZR sit at the end of that space
// Any special id not named here reads as zero
`default_nettype none

package gprFilePkg;

`include "gprfile_settings.svh"

	typedef logic [`ID_WIDTH-1:0] gprId_t;		// Register id
	typedef logic [`VALUE_WIDTH-1:0] regValue_t;	// Register value
	typedef logic [`IMM_WIDTH-1:0] immValue_t;	// Top bit is sign

	// Which bank holds the newest copy of a GPR
	typedef enum logic [1:0]
	{
		bankA = 2'd0,	// Written by lane A
		bankB = 2'd1,	// Written by lane B
		bankC = 2'd2	// Written by lane C
	} bankSel_t;

	// Special register ids
	localparam gprId_t idDlr = 6'h20;
	localparam gprId_t idDhr = 6'h21;
	localparam gprId_t idSp = 6'h2F;

	// Pseudo sources, never written and never forwarded
	localparam gprId_t idImm = 6'h3E;	// Lane immediate
	localparam gprId_t idZzr = 6'h3F;	// Reads zero

endpackage

`default_nettype wire

// ==== src/stageLanesIf.sv ====
// Destination ids and values of one pipeline stage, three lanes wide
// A lane that writes nothing carries idZzr as its id
`timescale 1ns/1ps
`default_nettype none

interface stageLanesIf
	import gprFilePkg::*;
();

	gprId_t idA;		// Lane 1 destination
	gprId_t idB;		// Lane 2 destination
	gprId_t idC;		// Lane 3 destination
	regValue_t valA;
	regValue_t valB;
	regValue_t valC;

	// Driven from the top level stage ports
	modport producer
	(
		output idA, idB, idC,
		output valA, valB, valC
	);

	// Banks, special registers and operand selectors
	modport consumer
	(
		input idA, idB, idC,
		input valA, valB, valC
	);

endinterface

`default_nettype wire

// ==== src/gprBanks.sv ====
// GPR storage, one bank per writeback lane plus a live-value table
// Writes commit on the clock edge when hold and wbFlush are both low
// Two lanes must never write the same GPR on one edge
// GPR contents are undefined until written, the live-value table resets to bank A
`timescale 1ns/1ps
`default_nettype none

`include "gprfile_settings.svh"

module gprBanks
	import gprFilePkg::*;
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic hold,
	input wire logic wbFlush,
	stageLanesIf.consumer wb,
	input wire gprId_t rdId0,
	input wire gprId_t rdId1,
	input wire gprId_t rdId2,
	input wire gprId_t rdId3,
	output regValue_t rdVal0,
	output regValue_t rdVal1,
	output regValue_t rdVal2,
	output regValue_t rdVal3
);

	localparam int IdxW = $clog2(`GPR_COUNT);

	regValue_t memA [`GPR_COUNT];		// Lane A copies
	regValue_t memB [`GPR_COUNT];		// Lane B copies
	regValue_t memC [`GPR_COUNT];		// Lane C copies
	bankSel_t liveSel [`GPR_COUNT];	// Newest bank per GPR

	logic wrEn;
	logic wrA, wrB, wrC;
	logic [IdxW-1:0] idxA, idxB, idxC;

	// Pick the live copy of one GPR
	function automatic regValue_t readGpr(input gprId_t id);
		logic [IdxW-1:0] idx;
		idx = id[IdxW-1:0];
		case (liveSel[idx])
			bankB: return memB[idx];
			bankC: return memC[idx];
			default: return memA[idx];
		endcase
	endfunction

	assign wrEn = !hold && !wbFlush;
	assign wrA = wrEn && (wb.idA < `GPR_COUNT);	// Specials and ZZR skip the banks
	assign wrB = wrEn && (wb.idB < `GPR_COUNT);
	assign wrC = wrEn && (wb.idC < `GPR_COUNT);
	assign idxA = wb.idA[IdxW-1:0];
	assign idxB = wb.idB[IdxW-1:0];
	assign idxC = wb.idC[IdxW-1:0];

	// Bank payload, no reset
	always_ff @(posedge clock)
	begin
		if (wrA)
			memA[idxA] <= wb.valA;
		if (wrB)
			memB[idxB] <= wb.valB;
		if (wrC)
			memC[idxC] <= wb.valC;
	end

	// Each lane marks its own bank as live
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `GPR_COUNT; i++)
				liveSel[i] <= bankA;
		end
		else
		begin
			if (wrA)
				liveSel[idxA] <= bankA;
			if (wrB)
				liveSel[idxB] <= bankB;
			if (wrC)
				liveSel[idxC] <= bankC;
		end
	end

	// Raw reads, selectors decide whether a GPR is wanted at all
	assign rdVal0 = readGpr(rdId0);
	assign rdVal1 = readGpr(rdId1);
	assign rdVal2 = readGpr(rdId2);
	assign rdVal3 = readGpr(rdId3);

	// Issue logic keeps writeback destinations distinct
	// otherwise the live-value table would point at an arbitrary bank
	wbGprDistinct: assert property (@(posedge clock) disable iff (!rstN)
		!((wrA && wrB && idxA == idxB) || (wrA && wrC && idxA == idxC) ||
			(wrB && wrC && idxB == idxC)));

endmodule

`default_nettype wire

// ==== src/sprBank.sv ====
// DLR, DHR and SP, written from the writeback lanes
// SP tracks spIn on every enabled edge unless a lane writes idSp on that edge
// All three clear on reset and freeze under hold or wbFlush
`timescale 1ns/1ps
`default_nettype none

module sprBank
	import gprFilePkg::*;
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic hold,
	input wire logic wbFlush,
	stageLanesIf.consumer wb,
	input wire regValue_t spIn,
	output regValue_t dlr,
	output regValue_t dhr,
	output regValue_t sp
);

	gprId_t laneId [3];
	regValue_t laneVal [3];
	logic [2:0] hitDlr, hitDhr, hitSp;	// Per lane match
	regValue_t dlrNext, dhrNext, spNext;
	logic wrEn;

	assign laneId[0] = wb.idA;
	assign laneId[1] = wb.idB;
	assign laneId[2] = wb.idC;
	assign laneVal[0] = wb.valA;
	assign laneVal[1] = wb.valB;
	assign laneVal[2] = wb.valC;
	assign wrEn = !hold && !wbFlush;

	always_comb
	begin
		dlrNext = dlr;		// DLR/DHR keep their value
		dhrNext = dhr;
		spNext = spIn;		// SP follows the external copy
		for (int i = 0; i < 3; i++)
		begin
			hitDlr[i] = (laneId[i] == idDlr);
			hitDhr[i] = (laneId[i] == idDhr);
			hitSp[i] = (laneId[i] == idSp);
			if (hitDlr[i])
				dlrNext = laneVal[i];
			if (hitDhr[i])
				dhrNext = laneVal[i];
			if (hitSp[i])
				spNext = laneVal[i];
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			dlr <= '0;
			dhr <= '0;
			sp <= '0;
		end
		else if (wrEn)
		begin
			dlr <= dlrNext;
			dhr <= dhrNext;
			sp <= spNext;
		end
	end

	// At most one writeback lane per special register
	wbSprDistinct: assert property (@(posedge clock) disable iff (!rstN)
		wrEn |-> ($onehot0(hitDlr) && $onehot0(hitDhr) && $onehot0(hitSp)));

endmodule

`default_nettype wire

// ==== src/operandSelect.sv ====
// One operand read port, purely combinational
// Decodes the source id, then overrides with the newest in-flight result
// Priority is EX1 over EX2 over WB, lane A over B over C
// Forwarding ignores wbFlush, a flushed WB result still forwards
`timescale 1ns/1ps
`default_nettype none

`include "gprfile_settings.svh"

module operandSelect
	import gprFilePkg::*;
(
	input wire gprId_t srcId,
	input wire regValue_t gprVal,		// Live bank copy for srcId
	input wire regValue_t dlr,
	input wire regValue_t dhr,
	input wire regValue_t sp,
	input wire immValue_t imm,		// Lane immediate
	stageLanesIf.consumer ex1,
	stageLanesIf.consumer ex2,
	stageLanesIf.consumer wb,
	output regValue_t operand
);

	regValue_t baseVal;
	regValue_t immExt;
	logic fwdOk;

	// Sign bit replicated into the upper word
	assign immExt = {{(`VALUE_WIDTH-`IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};

	// IMM and ZZR are constants, no stage can produce them
	assign fwdOk = (srcId != idImm) && (srcId != idZzr);

	// Base value from the register id
	always_comb
	begin
		if (srcId < `GPR_COUNT)
			baseVal = gprVal;
		else
		begin
			case (srcId)
				idDlr: baseVal = dlr;
				idDhr: baseVal = dhr;
				idSp: baseVal = sp;
				idImm: baseVal = immExt;
				default: baseVal = '0;		// ZZR and unknown ids
			endcase
		end
	end

	// Bypass, youngest stage first
	always_comb
	begin
		if (!fwdOk)
			operand = baseVal;
		else if (srcId == ex1.idA)
			operand = ex1.valA;
		else if (srcId == ex1.idB)
			operand = ex1.valB;
		else if (srcId == ex1.idC)
			operand = ex1.valC;
		else if (srcId == ex2.idA)
			operand = ex2.valA;
		else if (srcId == ex2.idB)
			operand = ex2.valB;
		else if (srcId == ex2.idC)
			operand = ex2.valC;
		else if (srcId == wb.idA)
			operand = wb.valA;		// Not yet committed to the banks
		else if (srcId == wb.idB)
			operand = wb.valB;
		else if (srcId == wb.idC)
			operand = wb.valC;
		else
			operand = baseVal;
	end

endmodule

`default_nettype wire

// ==== src/gprFileTop.sv ====
// Three-write, four-read GPR file with EX1/EX2/WB bypass
// Rs/Rt serve lane 1 and use immA, Ru/Rv serve lane 2 and use immB
// Reads settle in the cycle of their ids, writes commit on the next edge
// hold and wbFlush freeze all state, wbFlush does not stop forwarding
`timescale 1ns/1ps
`default_nettype none

module gprFileTop
	import gprFilePkg::*;
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic hold,
	input wire logic wbFlush,
	input wire gprId_t idRs,
	input wire gprId_t idRt,
	input wire gprId_t idRu,
	input wire gprId_t idRv,
	output regValue_t valRs,
	output regValue_t valRt,
	output regValue_t valRu,
	output regValue_t valRv,
	input wire immValue_t immA,
	input wire immValue_t immB,
	input wire gprId_t ex1IdA,
	input wire gprId_t ex1IdB,
	input wire gprId_t ex1IdC,
	input wire regValue_t ex1ValA,
	input wire regValue_t ex1ValB,
	input wire regValue_t ex1ValC,
	input wire gprId_t ex2IdA,
	input wire gprId_t ex2IdB,
	input wire gprId_t ex2IdC,
	input wire regValue_t ex2ValA,
	input wire regValue_t ex2ValB,
	input wire regValue_t ex2ValC,
	input wire gprId_t wbIdA,
	input wire gprId_t wbIdB,
	input wire gprId_t wbIdC,
	input wire regValue_t wbValA,
	input wire regValue_t wbValB,
	input wire regValue_t wbValC,
	input wire regValue_t spIn,
	output regValue_t dlrOut,
	output regValue_t dhrOut,
	output regValue_t spOut
);

	regValue_t gprRs, gprRt, gprRu, gprRv;	// Raw bank reads

	// Stage bundles, driven as producers from the plain ports
	stageLanesIf ex1Lanes();
	stageLanesIf ex2Lanes();
	stageLanesIf wbLanes();

	assign ex1Lanes.idA = ex1IdA;
	assign ex1Lanes.idB = ex1IdB;
	assign ex1Lanes.idC = ex1IdC;
	assign ex1Lanes.valA = ex1ValA;
	assign ex1Lanes.valB = ex1ValB;
	assign ex1Lanes.valC = ex1ValC;
	assign ex2Lanes.idA = ex2IdA;
	assign ex2Lanes.idB = ex2IdB;
	assign ex2Lanes.idC = ex2IdC;
	assign ex2Lanes.valA = ex2ValA;
	assign ex2Lanes.valB = ex2ValB;
	assign ex2Lanes.valC = ex2ValC;
	assign wbLanes.idA = wbIdA;
	assign wbLanes.idB = wbIdB;
	assign wbLanes.idC = wbIdC;
	assign wbLanes.valA = wbValA;
	assign wbLanes.valB = wbValB;
	assign wbLanes.valC = wbValC;

	gprBanks banks_i (
		.clock(clock), .rstN(rstN), .hold(hold), .wbFlush(wbFlush), .wb(wbLanes),
		.rdId0(idRs), .rdId1(idRt), .rdId2(idRu), .rdId3(idRv),
		.rdVal0(gprRs), .rdVal1(gprRt), .rdVal2(gprRu), .rdVal3(gprRv)
	);

	sprBank spr_i (
		.clock(clock), .rstN(rstN), .hold(hold), .wbFlush(wbFlush), .wb(wbLanes),
		.spIn(spIn), .dlr(dlrOut), .dhr(dhrOut), .sp(spOut)
	);

	// Lane 1 ports
	operandSelect selRs_i (
		.srcId(idRs), .gprVal(gprRs), .dlr(dlrOut), .dhr(dhrOut), .sp(spOut),
		.imm(immA), .ex1(ex1Lanes), .ex2(ex2Lanes), .wb(wbLanes), .operand(valRs)
	);

	operandSelect selRt_i (
		.srcId(idRt), .gprVal(gprRt), .dlr(dlrOut), .dhr(dhrOut), .sp(spOut),
		.imm(immA), .ex1(ex1Lanes), .ex2(ex2Lanes), .wb(wbLanes), .operand(valRt)
	);

	// Lane 2 ports
	operandSelect selRu_i (
		.srcId(idRu), .gprVal(gprRu), .dlr(dlrOut), .dhr(dhrOut), .sp(spOut),
		.imm(immB), .ex1(ex1Lanes), .ex2(ex2Lanes), .wb(wbLanes), .operand(valRu)
	);

	operandSelect selRv_i (
		.srcId(idRv), .gprVal(gprRv), .dlr(dlrOut), .dhr(dhrOut), .sp(spOut),
		.imm(immB), .ex1(ex1Lanes), .ex2(ex2Lanes), .wb(wbLanes), .operand(valRv)
	);

endmodule

`default_nettype wire

// ==== bench/gprFileTb.sv ====
// Directed testbench for the three-lane GPR file
// Inputs change just after the rising edge and outputs are checked at the falling edge
// Unused stage lanes carry idZzr
// The first failing check ends the run
// Writeback destinations stay distinct on every enabled edge
`timescale 1ns/1ps
`default_nettype none

`include "gprfile_settings.svh"

module gprFileTb
	import gprFilePkg::*;
();

	logic clock, rstN, hold, wbFlush;
	gprId_t idRs, idRt, idRu, idRv;
	regValue_t valRs, valRt, valRu, valRv;
	immValue_t immA, immB;
	gprId_t ex1IdA, ex1IdB, ex1IdC, ex2IdA, ex2IdB, ex2IdC, wbIdA, wbIdB, wbIdC;
	regValue_t ex1ValA, ex1ValB, ex1ValC, ex2ValA, ex2ValB, ex2ValC;
	regValue_t wbValA, wbValB, wbValC;
	regValue_t spIn, dlrOut, dhrOut, spOut;
	regValue_t gprModel [`GPR_COUNT];	// Expected committed GPRs
	regValue_t dlrModel;			// Expected DLR
	integer seed;

	gprFileTop dut_i (.*);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;	// 10 ns period
	end

	initial
	begin
		rstN = 1'b0;
		repeat (10) @(posedge clock);
		rstN <= 1'b1;
	end

	// Watchdog for the whole run
	initial
	begin
		repeat (2000) @(posedge clock);
		$display("Run did not finish within 2000 cycles");
		abortRun();
	end

	task automatic abortRun();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input regValue_t got, input regValue_t exp);
		assert (got === exp)
		else
		begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	function automatic regValue_t randomValue();
		return {$random(seed), $random(seed)};
	endfunction

	// Bit 32 of the immediate fills the upper word
	function automatic regValue_t signExtend(input immValue_t imm);
		regValue_t v;
		v = '0;
		v[`IMM_WIDTH-1:0] = imm;
		if (imm[`IMM_WIDTH-1])
			v[`VALUE_WIDTH-1:`IMM_WIDTH] = '1;
		return v;
	endfunction

	task automatic waitReset();
		int n;
		n = 0;
		while (rstN !== 1'b1 && n < 50)
		begin
			@(posedge clock);
			n++;
		end
		if (rstN !== 1'b1)
		begin
			$display("Reset was not released within 50 cycles");
			abortRun();
		end
	endtask

	task automatic idleStages();
		ex1IdA <= idZzr;
		ex1IdB <= idZzr;
		ex1IdC <= idZzr;
		ex2IdA <= idZzr;
		ex2IdB <= idZzr;
		ex2IdC <= idZzr;
		wbIdA <= idZzr;
		wbIdB <= idZzr;
		wbIdC <= idZzr;
	endtask

	// Stage 0 is EX1, 1 is EX2, anything else WB
	task automatic driveStage(input int stage, input gprId_t a, b, c,
		input regValue_t va, vb, vc);
		case (stage)
			0:
			begin
				ex1IdA <= a;
				ex1IdB <= b;
				ex1IdC <= c;
				ex1ValA <= va;
				ex1ValB <= vb;
				ex1ValC <= vc;
			end
			1:
			begin
				ex2IdA <= a;
				ex2IdB <= b;
				ex2IdC <= c;
				ex2ValA <= va;
				ex2ValB <= vb;
				ex2ValC <= vc;
			end
			default:
			begin
				wbIdA <= a;
				wbIdB <= b;
				wbIdC <= c;
				wbValA <= va;
				wbValB <= vb;
				wbValC <= vc;
			end
		endcase
	endtask

	task automatic pointReads(input gprId_t id);
		idRs <= id;
		idRt <= id;
		idRu <= id;
		idRv <= id;
	endtask

	task automatic expectAllPorts(input regValue_t exp);
		checkValue("valRs", valRs, exp);
		checkValue("valRt", valRt, exp);
		checkValue("valRu", valRu, exp);
		checkValue("valRv", valRv, exp);
	endtask

	task automatic noteWrite(input gprId_t id, input regValue_t val);
		if (id < `GPR_COUNT)
			gprModel[id] = val;
	endtask

	// One enabled writeback edge with the lanes idle afterwards
	task automatic commitWb(input gprId_t a, b, c, input regValue_t va, vb, vc);
		@(posedge clock);
		wbIdA <= a;
		wbIdB <= b;
		wbIdC <= c;
		wbValA <= va;
		wbValB <= vb;
		wbValC <= vc;
		@(posedge clock);	// Commit edge
		idleStages();
		noteWrite(a, va);
		noteWrite(b, vb);
		noteWrite(c, vc);
	endtask

	// Read one GPR on all ports with idle stages
	task automatic readBack(input gprId_t id);
		@(posedge clock);
		pointReads(id);
		@(negedge clock);
		expectAllPorts(gprModel[id]);
	endtask

	task automatic resetValues();
		@(negedge clock);
		checkValue("dlrOut", dlrOut, '0);
		checkValue("dhrOut", dhrOut, '0);
		checkValue("spOut", spOut, '0);
		expectAllPorts('0);		// Ports sit on idZzr
	endtask

	task automatic laneWrites();
		commitWb(6'd3, 6'd7, 6'd12, randomValue(), randomValue(), randomValue());
		readBack(6'd3);
		readBack(6'd7);
		readBack(6'd12);
		// Same register from other lanes moves the live table
		commitWb(idZzr, idZzr, 6'd3, '0, '0, randomValue());
		readBack(6'd3);
		commitWb(idZzr, 6'd3, idZzr, '0, randomValue(), '0);
		readBack(6'd3);
		commitWb(6'd3, idZzr, idZzr, randomValue(), '0, '0);
		readBack(6'd3);
		readBack(6'd7);		// Untouched
	endtask

	task automatic specialRegs();
		regValue_t d, h, s1, s2, v;
		d = randomValue();
		h = randomValue();
		s1 = randomValue();
		s2 = randomValue();
		v = randomValue();
		commitWb(idZzr, idDlr, idDhr, '0, d, h);
		dlrModel = d;
		@(posedge clock);
		idRs <= idDlr;
		idRt <= idDhr;
		idRu <= idSp;
		idRv <= idZzr;
		spIn <= s1;
		@(posedge clock);		// SP loads s1
		@(negedge clock);
		checkValue("dlrOut", dlrOut, d);
		checkValue("dhrOut", dhrOut, h);
		checkValue("valRs", valRs, d);
		checkValue("valRt", valRt, h);
		checkValue("spOut", spOut, s1);
		checkValue("valRu", valRu, s1);
		@(posedge clock);
		spIn <= s2;
		wbIdA <= idSp;
		wbValA <= v;
		@(posedge clock);		// Lane beats spIn here
		wbIdA <= idZzr;
		@(negedge clock);
		checkValue("spOut", spOut, v);
		checkValue("valRu", valRu, v);
		@(posedge clock);
		@(negedge clock);
		checkValue("spOut", spOut, s2);	// Back to following spIn
	endtask

	task automatic holdAndFlush();
		regValue_t oldGpr;
		oldGpr = gprModel[7];
		for (int mode = 0; mode < 2; mode++)
		begin
			@(posedge clock);
			hold <= (mode == 0);
			wbFlush <= (mode == 1);
			pointReads(6'd7);
			wbIdA <= 6'd7;
			wbValA <= randomValue();
			wbIdB <= idDlr;
			wbValB <= randomValue();
			@(posedge clock);	// Blocked edge
			hold <= 1'b0;
			wbFlush <= 1'b0;
			idleStages();
			@(negedge clock);
			expectAllPorts(oldGpr);
			checkValue("dlrOut", dlrOut, dlrModel);
		end
	endtask

	// wbFlush stays high so nothing commits while WB still forwards
	task automatic bypassOrder();
		regValue_t e1, e2, w;
		e1 = randomValue();
		e2 = randomValue();
		w = randomValue();
		@(posedge clock);
		wbFlush <= 1'b1;
		pointReads(6'd12);
		ex1IdA <= 6'd12;
		ex1ValA <= e1;
		ex2IdA <= 6'd12;
		ex2ValA <= e2;
		wbIdA <= 6'd12;
		wbValA <= w;
		@(negedge clock);
		expectAllPorts(e1);
		@(posedge clock);
		ex1IdA <= idZzr;
		@(negedge clock);
		expectAllPorts(e2);
		@(posedge clock);
		ex2IdA <= idZzr;
		@(negedge clock);
		expectAllPorts(w);
		@(posedge clock);
		wbIdA <= idZzr;
		@(negedge clock);
		expectAllPorts(gprModel[12]);	// Flushed edges wrote nothing
		// Lane order inside each stage
		for (int s = 0; s < 3; s++)
		begin
			@(posedge clock);
			driveStage(s, 6'd12, 6'd12, 6'd12, e1, e2, w);
			@(negedge clock);
			expectAllPorts(e1);
			@(posedge clock);
			driveStage(s, idZzr, 6'd12, 6'd12, e1, e2, w);
			@(negedge clock);
			expectAllPorts(e2);
			@(posedge clock);
			driveStage(s, idZzr, idZzr, 6'd12, e1, e2, w);
			@(negedge clock);
			expectAllPorts(w);
			@(posedge clock);
			driveStage(s, idZzr, idZzr, idZzr, e1, e2, w);
		end
		// IMM and ZZR in flight must not leak
		@(posedge clock);
		immA <= {1'b1, $random(seed)};
		immB <= {1'b0, $random(seed)};
		ex1IdC <= idImm;
		idRs <= idImm;
		idRt <= idZzr;
		idRu <= idImm;
		idRv <= idZzr;
		@(negedge clock);
		checkValue("valRs", valRs, signExtend(immA));
		checkValue("valRt", valRt, '0);
		checkValue("valRu", valRu, signExtend(immB));
		checkValue("valRv", valRv, '0);
		@(posedge clock);
		wbFlush <= 1'b0;
		idleStages();
	endtask

	task automatic immediateReads();
		immValue_t ia, ib;
		logic sgn;
		for (int k = 0; k < 2; k++)
		begin
			sgn = (k == 1);
			ia = {sgn, $random(seed)};
			ib = {~sgn, $random(seed)};	// Opposite sign on lane 2
			@(posedge clock);
			immA <= ia;
			immB <= ib;
			pointReads(idImm);
			@(negedge clock);
			checkValue("valRs", valRs, signExtend(ia));
			checkValue("valRt", valRt, signExtend(ia));
			checkValue("valRu", valRu, signExtend(ib));
			checkValue("valRv", valRv, signExtend(ib));
		end
	endtask

	initial
	begin
		seed = 78949;
		dlrModel = '0;
		hold = 1'b0;
		wbFlush = 1'b0;
		idRs = idZzr;
		idRt = idZzr;
		idRu = idZzr;
		idRv = idZzr;
		immA = '0;
		immB = '0;
		ex1IdA = idZzr;
		ex1IdB = idZzr;
		ex1IdC = idZzr;
		ex2IdA = idZzr;
		ex2IdB = idZzr;
		ex2IdC = idZzr;
		wbIdA = idZzr;
		wbIdB = idZzr;
		wbIdC = idZzr;
		ex1ValA = '0;
		ex1ValB = '0;
		ex1ValC = '0;
		ex2ValA = '0;
		ex2ValB = '0;
		ex2ValC = '0;
		wbValA = '0;
		wbValB = '0;
		wbValC = '0;
		spIn = '0;			// Keeps SP at zero through the reset check
		waitReset();
		resetValues();
		laneWrites();
		specialRegs();
		holdAndFlush();
		bypassOrder();
		immediateReads();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/gprFilePkg.sv
src/stageLanesIf.sv
src/gprBanks.sv
src/sprBank.sv
src/operandSelect.sv
src/gprFileTop.sv
bench/gprFileTb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the GPR file testbench with Verilator and runs it
# The result is read from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module gprFileTb \
	-Mdir obj_dir -o gprFileSim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }
./obj_dir/gprFileSim > sim.log 2>&1
! grep -q "Done: errors found" sim.log && grep -q "Done: no errors" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
